// File: compile.f
hdl/dma_pkg.sv
hdl/dma_desc_if.sv
hdl/dma_regs.sv
hdl/dma_chan.sv
hdl/dma_ctrl.sv
hdl/dma_top.sv
sim/wb_mem_model.sv
sim/tb_dma.sv

// File: hdl/dma_chan.sv
// dma channel slot: holds one descriptor and counts its length down to done
module dma_chan (
   input  logic     wb_clk_i,
   input  logic     wb_rst_i,
   dma_desc_if.chan desc
);

   logic [63:0]                  desc_q [dma_pkg::DESC_BEATS];
   logic [dma_pkg::DC_W-1:0]     dc;
   logic [dma_pkg::DC_LEN_W-1:0] count_q;
   logic                         loaded_q;   // length taken from dc

   // descriptor storage, written beat by beat during the fetch
   always_ff @(posedge wb_clk_i) begin
      if (desc.we) begin
         desc_q[desc.beat] <= desc.dat;
      end
   end

   assign dc = desc_q[1][dma_pkg::DC_W-1:0];

   // first start cycle loads the length, then one word per cycle
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         count_q  <= '0;
         loaded_q <= 1'b0;
      end else if (desc.reset) begin
         count_q  <= '0;
         loaded_q <= 1'b0;
      end else if (desc.start) begin
         if (!loaded_q) begin
            count_q  <= dc[dma_pkg::DC_LEN_LSB +: dma_pkg::DC_LEN_W];
            loaded_q <= 1'b1;
         end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   assign desc.done  = loaded_q && (count_q == '0);   // sticky until reset
   assign desc.count = count_q;

endmodule

// File: hdl/dma_ctrl.sv
// dma control FSM: descriptor fetch, status write-back and wishbone burst master
module dma_ctrl (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   output logic               wbm_cyc_o,
   output logic               wbm_stb_o,
   output logic               wbm_we_o,
   output logic               wbm_cab_o,
   output logic [7:0]         wbm_sel_o,
   output logic [31:0]        wbm_adr_o,
   output logic [63:0]        wbm_dat_o,
   input  logic [63:0]        wbm_dat_i,
   input  logic               wbm_ack_i,
   input  logic               wbm_err_i,
   input  logic               wbm_rty_i,
   input  dma_pkg::desc_adr_t ndar_i,
   input  logic               ndar_dirty_i,
   input  logic               enable_i,
   input  logic               append_i,
   input  logic               int_clear_i,
   output logic               ndar_dirty_clear_o,
   output logic               append_clear_o,
   output dma_pkg::desc_adr_t dar_o,
   output logic               busy_o,
   output logic               int_o,
   dma_desc_if.ctrl           desc0,
   dma_desc_if.ctrl           desc1
);

   dma_pkg::ctrl_state_t     state_q, state_d;
   logic                     cyc_q, cyc_d;
   logic                     we_q, we_d;
   logic                     append_mode_q, append_mode_d;
   logic                     dirty_clr_d, app_clr_d;
   logic                     start0_q, start0_d;
   logic                     start1_q, start1_d;
   logic                     rst0_q, rst1_q;
   dma_pkg::desc_adr_t       dar_d;
   logic                     int_set;
   logic                     burst_go;
   dma_pkg::desc_adr_t       burst_adr;
   dma_pkg::desc_adr_t       adr_q;
   logic [1:0]               beat_q;
   logic                     ack_ok;
   logic                     last_beat;
   dma_pkg::desc_adr_t       next_desc_q;
   dma_pkg::desc_adr_t       ctl_adr0_q, ctl_adr1_q;
   dma_pkg::desc_adr_t       cdar0_q, cdar1_q;
   logic [dma_pkg::DC_W-1:0] dc0_q, dc1_q;

   // status beat: remaining count above the descriptor's dc
   function automatic logic [63:0] stat_word(input logic [dma_pkg::DC_W-1:0] dc,
                                             input logic [dma_pkg::DC_LEN_W-1:0] cnt);
      stat_word = {24'd0, cnt, 8'd0, dc};
   endfunction

   assign ack_ok    = cyc_q && wbm_ack_i && !wbm_err_i && !wbm_rty_i;
   assign last_beat = ack_ok && (beat_q == 2'(dma_pkg::DESC_BEATS - 1));

   always_comb begin
      state_d       = state_q;
      cyc_d         = cyc_q;
      we_d          = we_q;
      append_mode_d = append_mode_q;
      dirty_clr_d   = 1'b0;
      app_clr_d     = 1'b0;
      start0_d      = start0_q;
      start1_d      = start1_q;
      dar_d         = dar_o;
      int_set       = 1'b0;
      burst_go      = 1'b0;
      burst_adr     = adr_q;
      unique case (state_q)
         dma_pkg::IDLE: begin
            if (enable_i && ndar_dirty_i) begin
               dirty_clr_d = 1'b1;
               burst_go    = 1'b1;
               burst_adr   = ndar_i;
               we_d        = 1'b0;
               state_d     = dma_pkg::CMD0;
            end else if (enable_i && append_i) begin
               append_mode_d = 1'b1;           // re-read the descriptor at dar
               burst_go      = 1'b1;
               burst_adr     = dar_o;
               we_d          = 1'b0;
               state_d       = dma_pkg::CMD0;
            end
         end
         dma_pkg::CMD0: begin
            if (last_beat) begin
               cyc_d   = 1'b0;
               state_d = dma_pkg::NEXT0;
            end
         end
         dma_pkg::NEXT0: begin
            if (append_mode_q) begin
               app_clr_d     = 1'b1;
               append_mode_d = 1'b0;
            end else begin
               start0_d = 1'b1;
            end
            if (dc0_q[dma_pkg::DC_CHAIN_BIT]) begin
               burst_go  = 1'b1;
               burst_adr = next_desc_q;
               we_d      = 1'b0;
               state_d   = append_mode_q ? dma_pkg::CMD0 : dma_pkg::CMD1;
            end else begin
               // a re-read chain still ends here, nothing to run
               state_d = append_mode_q ? dma_pkg::IDLE : dma_pkg::WAIT0;
            end
         end
         dma_pkg::CMD1: begin
            if (last_beat) begin
               cyc_d   = 1'b0;
               state_d = dma_pkg::WAIT0;
            end
         end
         dma_pkg::WAIT0: begin
            start1_d = dc0_q[dma_pkg::DC_CHAIN_BIT];   // slot 1 holds a descriptor
            if (desc0.done) begin
               if (dc0_q[dma_pkg::DC_CTL_BIT]) begin
                  burst_go  = 1'b1;
                  burst_adr = ctl_adr0_q;
                  we_d      = 1'b1;
                  state_d   = dma_pkg::CTL0;
               end else begin
                  state_d = dma_pkg::TR0;
               end
            end
         end
         dma_pkg::CTL0: begin
            if (last_beat) begin
               cyc_d   = 1'b0;
               state_d = dma_pkg::TR0;
            end
         end
         dma_pkg::TR0: begin
            dar_d    = cdar0_q;
            int_set  = dc0_q[dma_pkg::DC_INT_BIT];
            start0_d = 1'b0;
            state_d  = dc0_q[dma_pkg::DC_CHAIN_BIT] ? dma_pkg::WAIT1 : dma_pkg::IDLE;
         end
         dma_pkg::WAIT1: begin
            if (desc1.done) begin
               if (dc1_q[dma_pkg::DC_CTL_BIT]) begin
                  burst_go  = 1'b1;
                  burst_adr = ctl_adr1_q;
                  we_d      = 1'b1;
                  state_d   = dma_pkg::CTL1;
               end else begin
                  state_d = dma_pkg::TR1;
               end
            end
         end
         dma_pkg::CTL1: begin
            if (last_beat) begin
               cyc_d   = 1'b0;
               state_d = dma_pkg::TR1;
            end
         end
         dma_pkg::TR1: begin
            dar_d    = cdar1_q;
            int_set  = dc1_q[dma_pkg::DC_INT_BIT];
            start1_d = 1'b0;
            state_d  = dc1_q[dma_pkg::DC_CHAIN_BIT] ? dma_pkg::NEXT1 : dma_pkg::IDLE;
         end
         dma_pkg::NEXT1: begin
            burst_go  = 1'b1;
            burst_adr = next_desc_q;
            we_d      = 1'b0;
            state_d   = dma_pkg::CMD0;
         end
         default: state_d = dma_pkg::IDLE;
      endcase
      if (burst_go) begin
         cyc_d = 1'b1;
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= dma_pkg::IDLE;
         cyc_q              <= 1'b0;
         we_q               <= 1'b0;
         append_mode_q      <= 1'b0;
         ndar_dirty_clear_o <= 1'b0;
         append_clear_o     <= 1'b0;
         start0_q           <= 1'b0;
         start1_q           <= 1'b0;
         rst0_q             <= 1'b1;   // slots held clear during reset
         rst1_q             <= 1'b1;
         dar_o              <= '0;
         int_o              <= 1'b0;
      end else begin
         state_q            <= state_d;
         cyc_q              <= cyc_d;
         we_q               <= we_d;
         append_mode_q      <= append_mode_d;
         ndar_dirty_clear_o <= dirty_clr_d;
         append_clear_o     <= app_clr_d;
         start0_q           <= start0_d;
         start1_q           <= start1_d;
         rst0_q             <= (state_q == dma_pkg::TR0);
         rst1_q             <= (state_q == dma_pkg::TR1);
         dar_o              <= dar_d;
         if (int_set) begin
            int_o <= 1'b1;
         end else if (int_clear_i) begin
            int_o <= 1'b0;
         end
      end
   end

   // burst address and beat counter, move only on a clean ack
   always_ff @(posedge wb_clk_i) begin
      if (burst_go) begin
         adr_q  <= burst_adr;
         beat_q <= 2'd0;
      end else if (ack_ok) begin
         adr_q  <= adr_q + 1'b1;
         beat_q <= beat_q + 1'b1;
      end
   end

   // descriptor fields the FSM itself needs
   always_ff @(posedge wb_clk_i) begin
      if (ack_ok && (state_q == dma_pkg::CMD0 || state_q == dma_pkg::CMD1)) begin
         if (beat_q == 2'd0) begin
            next_desc_q <= wbm_dat_i[31:3];
         end
      end
      if (ack_ok && state_q == dma_pkg::CMD0) begin
         if (beat_q == 2'd0) begin
            ctl_adr0_q <= wbm_dat_i[63:35];
            cdar0_q    <= adr_q;
         end
         if (beat_q == 2'd1) begin
            dc0_q <= wbm_dat_i[dma_pkg::DC_W-1:0];
         end
      end
      if (ack_ok && state_q == dma_pkg::CMD1) begin
         if (beat_q == 2'd0) begin
            ctl_adr1_q <= wbm_dat_i[63:35];
            cdar1_q    <= adr_q;
         end
         if (beat_q == 2'd1) begin
            dc1_q <= wbm_dat_i[dma_pkg::DC_W-1:0];
         end
      end
   end

   assign wbm_cyc_o = cyc_q;
   assign wbm_stb_o = cyc_q;
   assign wbm_cab_o = cyc_q;
   assign wbm_sel_o = {8{cyc_q}};
   assign wbm_we_o  = we_q;
   assign wbm_adr_o = {adr_q, 3'b000};
   assign wbm_dat_o = (state_q == dma_pkg::CTL1) ? stat_word(dc1_q, desc1.count)
                                                 : stat_word(dc0_q, desc0.count);

   assign busy_o = (state_q != dma_pkg::IDLE);

   // slot 0 is skipped while re-reading in append mode
   assign desc0.we    = ack_ok && (state_q == dma_pkg::CMD0) && !append_mode_q;
   assign desc0.beat  = beat_q;
   assign desc0.dat   = wbm_dat_i;
   assign desc0.start = start0_q;
   assign desc0.reset = rst0_q;

   assign desc1.we    = ack_ok && (state_q == dma_pkg::CMD1);
   assign desc1.beat  = beat_q;
   assign desc1.dat   = wbm_dat_i;
   assign desc1.start = start1_q;
   assign desc1.reset = rst1_q;

endmodule

// File: hdl/dma_desc_if.sv
// descriptor load path between the control FSM and one channel slot
interface dma_desc_if;

   logic                          we;     // one beat written this cycle
   logic [1:0]                    beat;   // beat index within the descriptor
   logic [63:0]                   dat;
   logic                          start;  // level, slot runs while high
   logic                          reset;  // one-cycle slot clear
   logic                          done;
   logic [dma_pkg::DC_LEN_W-1:0]  count;  // remaining length

   modport ctrl (
      output we, beat, dat, start, reset,
      input  done, count
   );

   modport chan (
      input  we, beat, dat, start, reset,
      output done, count
   );

endinterface

// File: hdl/dma_pkg.sv
// dma package: control state encoding, descriptor field positions and register map
package dma_pkg;

   // control FSM states
   typedef enum logic [3:0] {
      IDLE  = 4'h0,
      CMD0  = 4'h1,
      NEXT0 = 4'h2,
      CMD1  = 4'h3,
      WAIT0 = 4'h4,
      CTL0  = 4'h5,
      TR0   = 4'h6,
      WAIT1 = 4'h7,
      CTL1  = 4'h8,
      TR1   = 4'h9,
      NEXT1 = 4'ha
   } ctrl_state_t;

   // beats per descriptor fetch and per status write
   localparam int DESC_BEATS = 4;

   // descriptor control word (dc), taken from beat 1
   localparam int DC_W         = 24;
   localparam int DC_CTL_BIT   = 7;   // status write-back request
   localparam int DC_CHAIN_BIT = 14;  // another descriptor follows
   localparam int DC_INT_BIT   = 15;  // interrupt on completion
   localparam int DC_LEN_LSB   = 16;
   localparam int DC_LEN_W     = 8;

   // register map
   localparam logic [1:0] REG_NDAR = 2'd0;
   localparam logic [1:0] REG_CTRL = 2'd1;
   localparam logic [1:0] REG_DAR  = 2'd2;
   localparam logic [1:0] REG_STAT = 2'd3;

   // 8-byte aligned bus address, bits 31..3
   typedef logic [31:3] desc_adr_t;

endpackage

// File: hdl/dma_regs.sv
// dma register block: next descriptor address, control bits and status readback
module dma_regs (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               reg_we_i,
   input  logic [1:0]         reg_adr_i,
   input  logic [31:0]        reg_dat_i,
   output logic [31:0]        reg_dat_o,
   input  dma_pkg::desc_adr_t dar_i,
   input  logic               busy_i,
   input  logic               int_i,
   input  logic               ndar_dirty_clear_i,
   input  logic               append_clear_i,
   output dma_pkg::desc_adr_t ndar_o,
   output logic               ndar_dirty_o,
   output logic               enable_o,
   output logic               append_o,
   output logic               int_clear_o
);

   logic wr_ndar;
   logic wr_ctrl;
   logic wr_stat;

   assign wr_ndar = reg_we_i && (reg_adr_i == dma_pkg::REG_NDAR);
   assign wr_ctrl = reg_we_i && (reg_adr_i == dma_pkg::REG_CTRL);
   assign wr_stat = reg_we_i && (reg_adr_i == dma_pkg::REG_STAT);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ndar_o       <= '0;
         ndar_dirty_o <= 1'b0;
         enable_o     <= 1'b0;
         append_o     <= 1'b0;
         int_clear_o  <= 1'b0;
      end else begin
         if (wr_ndar) begin
            ndar_o <= reg_dat_i[31:3];
         end
         // a fresh write wins over the clear from the FSM
         if (wr_ndar) begin
            ndar_dirty_o <= 1'b1;
         end else if (ndar_dirty_clear_i) begin
            ndar_dirty_o <= 1'b0;
         end
         if (wr_ctrl) begin
            enable_o <= reg_dat_i[0];
         end
         if (wr_ctrl && reg_dat_i[1]) begin
            append_o <= 1'b1;            // set only, FSM clears it
         end else if (append_clear_i) begin
            append_o <= 1'b0;
         end
         int_clear_o <= wr_stat && reg_dat_i[0];   // one-cycle pulse
      end
   end

   always_comb begin
      case (reg_adr_i)
         dma_pkg::REG_NDAR: reg_dat_o = {ndar_o, 3'b000};
         dma_pkg::REG_CTRL: reg_dat_o = {29'd0, ndar_dirty_o, append_o, enable_o};
         dma_pkg::REG_DAR:  reg_dat_o = {dar_i, 3'b000};
         default:           reg_dat_o = {30'd0, int_i, busy_i};
      endcase
   end

endmodule

// File: hdl/dma_top.sv
// dma top: register block, descriptor control FSM and two channel slots
module dma_top (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   output logic        wbm_cyc_o,
   output logic        wbm_stb_o,
   output logic        wbm_we_o,
   output logic        wbm_cab_o,
   output logic [7:0]  wbm_sel_o,
   output logic [31:0] wbm_adr_o,
   output logic [63:0] wbm_dat_o,
   input  logic [63:0] wbm_dat_i,
   input  logic        wbm_ack_i,
   input  logic        wbm_err_i,
   input  logic        wbm_rty_i,
   input  logic        reg_we_i,
   input  logic [1:0]  reg_adr_i,
   input  logic [31:0] reg_dat_i,
   output logic [31:0] reg_dat_o,
   output logic        int_o,
   output logic        busy_o
);

   dma_pkg::desc_adr_t ndar;
   dma_pkg::desc_adr_t dar;
   logic               ndar_dirty;
   logic               enable;
   logic               append;
   logic               int_clear;
   logic               ndar_dirty_clear;
   logic               append_clear;

   dma_desc_if desc0_if ();
   dma_desc_if desc1_if ();

   dma_regs i_regs (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .reg_we_i           (reg_we_i),
      .reg_adr_i          (reg_adr_i),
      .reg_dat_i          (reg_dat_i),
      .reg_dat_o          (reg_dat_o),
      .dar_i              (dar),
      .busy_i             (busy_o),
      .int_i              (int_o),
      .ndar_dirty_clear_i (ndar_dirty_clear),
      .append_clear_i     (append_clear),
      .ndar_o             (ndar),
      .ndar_dirty_o       (ndar_dirty),
      .enable_o           (enable),
      .append_o           (append),
      .int_clear_o        (int_clear)
   );

   dma_ctrl i_ctrl (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .wbm_cyc_o          (wbm_cyc_o),
      .wbm_stb_o          (wbm_stb_o),
      .wbm_we_o           (wbm_we_o),
      .wbm_cab_o          (wbm_cab_o),
      .wbm_sel_o          (wbm_sel_o),
      .wbm_adr_o          (wbm_adr_o),
      .wbm_dat_o          (wbm_dat_o),
      .wbm_dat_i          (wbm_dat_i),
      .wbm_ack_i          (wbm_ack_i),
      .wbm_err_i          (wbm_err_i),
      .wbm_rty_i          (wbm_rty_i),
      .ndar_i             (ndar),
      .ndar_dirty_i       (ndar_dirty),
      .enable_i           (enable),
      .append_i           (append),
      .int_clear_i        (int_clear),
      .ndar_dirty_clear_o (ndar_dirty_clear),
      .append_clear_o     (append_clear),
      .dar_o              (dar),
      .busy_o             (busy_o),
      .int_o              (int_o),
      .desc0              (desc0_if.ctrl),
      .desc1              (desc1_if.ctrl)
   );

   dma_chan i_chan0 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .desc     (desc0_if.chan)
   );

   dma_chan i_chan1 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .desc     (desc1_if.chan)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the dma testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_dma -o tb_dma_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_dma_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
   exit 1
fi
exit 0

// File: sim/tb_dma.sv
// dma testbench: directed descriptor chain tests against a wishbone memory model
module tb_dma;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] LFSR_SEED = 32'h3c397066;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        wbm_cyc_o;
   logic        wbm_stb_o;
   logic        wbm_we_o;
   logic        wbm_cab_o;
   logic [7:0]  wbm_sel_o;
   logic [31:0] wbm_adr_o;
   logic [63:0] wbm_dat_o;
   logic [63:0] wbm_dat_i;
   logic        wbm_ack_i;
   logic        wbm_err_i;
   logic        wbm_rty_i;
   logic        reg_we_i;
   logic [1:0]  reg_adr_i;
   logic [31:0] reg_dat_i;
   logic [31:0] reg_dat_o;
   logic        int_o;
   logic        busy_o;

   logic [1:0]  ack_delay;
   logic        ld_we;
   logic [7:0]  ld_idx;
   logic [63:0] ld_dat;
   logic [31:0] lfsr_q;
   int          errors;
   int          checks;
   int          cycles;
   int          wd_deadline;
   logic        wd_armed;

   dma_top i_dut (.*);

   wb_mem_model i_mem (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc_i    (wbm_cyc_o),
      .stb_i    (wbm_stb_o),
      .we_i     (wbm_we_o),
      .adr_i    (wbm_adr_o),
      .dat_i    (wbm_dat_o),
      .dat_o    (wbm_dat_i),
      .ack_o    (wbm_ack_i),
      .delay_i  (ack_delay),
      .ld_we_i  (ld_we),
      .ld_idx_i (ld_idx),
      .ld_dat_i (ld_dat)
   );

   always #10 wb_clk_i = ~wb_clk_i;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // new ack delay each cycle, one lfsr step per bit
   always @(negedge wb_clk_i) begin
      logic [31:0] s1;
      logic [31:0] s2;
      if (wb_rst_i) begin
         lfsr_q    <= LFSR_SEED;
         ack_delay <= 2'd0;
      end else begin
         s1 = lfsr_next(lfsr_q);
         s2 = lfsr_next(s1);
         ack_delay <= {s1[0], s2[0]};
         lfsr_q    <= s2;
      end
   end

   // cycle counter and watchdog while waiting on the DUT
   always @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
         if (wd_armed && cycles > wd_deadline) begin
            $display("timeout: busy_o did not fall at cycle %0d", cycles);
            $display("=== FAIL ===");
            $finish;
         end
      end
   end

   function automatic dma_pkg::desc_adr_t to_adr(input logic [31:0] a);
      return a[31:3];
   endfunction

   function automatic logic [dma_pkg::DC_W-1:0] make_dc(input logic [7:0] len,
         input logic chain, input logic irq, input logic ctl);
      logic [dma_pkg::DC_W-1:0] dc;
      dc = '0;
      dc[dma_pkg::DC_LEN_LSB +: dma_pkg::DC_LEN_W] = len;
      dc[dma_pkg::DC_CHAIN_BIT] = chain;
      dc[dma_pkg::DC_INT_BIT]   = irq;
      dc[dma_pkg::DC_CTL_BIT]   = ctl;
      return dc;
   endfunction

   task automatic check_adr(input string name, input dma_pkg::desc_adr_t got,
                            input dma_pkg::desc_adr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, {got, 3'b000},
                  {exp, 3'b000});
      end
   endtask

   task automatic check_dc(input string name, input logic [dma_pkg::DC_W-1:0] got,
                           input logic [dma_pkg::DC_W-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("expected %0d %s on the bus but saw %0d", exp, what, got);
      end
   endtask

   // stb, cab and every sel bit stay high while a burst holds cyc
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && wbm_cyc_o) begin
         check_bit("wbm_stb_o", wbm_stb_o, 1'b1);
         check_bit("wbm_cab_o", wbm_cab_o, 1'b1);
         for (int i = 0; i < 8; i++) begin
            check_bit("wbm_sel_o", wbm_sel_o[i], 1'b1);
         end
      end
   end

   // four consecutive beats starting at adr in the read or write log
   task automatic check_burst(input logic is_wr, input int first, input logic [31:0] adr);
      for (int i = 0; i < dma_pkg::DESC_BEATS; i++) begin
         if (is_wr) begin
            check_adr("write adr", to_adr(i_mem.wr_adr_log[first + i]), to_adr(adr + 8 * i));
         end else begin
            check_adr("read adr", to_adr(i_mem.rd_log[first + i]), to_adr(adr + 8 * i));
         end
      end
   endtask

   task automatic mem_load(input logic [31:0] adr, input logic [63:0] dat);
      @(negedge wb_clk_i);
      ld_we  = 1'b1;
      ld_idx = adr[10:3];
      ld_dat = dat;
      @(negedge wb_clk_i);
      ld_we  = 1'b0;
   endtask

   // beat 0 holds ctl address over next pointer, beat 1 holds dc
   task automatic put_desc(input logic [31:0] adr, input logic [31:0] nxt,
                           input logic [31:0] ctl, input logic [dma_pkg::DC_W-1:0] dc);
      mem_load(adr, {ctl, nxt});
      mem_load(adr + 32'd8, {40'd0, dc});
   endtask

   task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
      @(negedge wb_clk_i);
      reg_we_i  = 1'b1;
      reg_adr_i = adr;
      reg_dat_i = dat;
      @(negedge wb_clk_i);
      reg_we_i  = 1'b0;
   endtask

   task automatic reg_read(input logic [1:0] adr, output logic [31:0] dat);
      @(negedge wb_clk_i);
      reg_adr_i = adr;
      #5;
      dat = reg_dat_o;
   endtask

   // limit is the total length plus 40 cycles per descriptor
   task automatic wait_done(input int ndesc, input int total_len);
      int n;
      n           = 0;
      wd_deadline = cycles + total_len + 40 * ndesc;
      wd_armed    = 1'b1;
      do begin
         @(negedge wb_clk_i);
         n++;
      end while (busy_o || n < 3);   // busy rises within two edges
      wd_armed = 1'b0;
   endtask

   task automatic test_single();
      int          rd0;
      logic [31:0] d;
      rd0 = i_mem.rd_cnt;
      put_desc(32'h100, 32'h0, 32'h0, make_dc(8'd5, 1'b0, 1'b0, 1'b0));
      reg_write(dma_pkg::REG_NDAR, 32'h100);
      reg_read(dma_pkg::REG_NDAR, d);
      check_adr("ndar", d[31:3], to_adr(32'h100));
      reg_write(dma_pkg::REG_CTRL, 32'h1);
      wait_done(1, 5);
      reg_read(dma_pkg::REG_DAR, d);
      check_adr("dar", d[31:3], to_adr(32'h100));
      check_count("descriptor reads", i_mem.rd_cnt - rd0, 4);
      check_burst(1'b0, rd0, 32'h100);
   endtask

   task automatic test_chain();
      int          rd0;
      logic [31:0] d;
      rd0 = i_mem.rd_cnt;
      put_desc(32'h200, 32'h280, 32'h0, make_dc(8'd3, 1'b1, 1'b0, 1'b0));
      put_desc(32'h280, 32'h0, 32'h0, make_dc(8'd4, 1'b0, 1'b0, 1'b0));
      reg_write(dma_pkg::REG_NDAR, 32'h200);   // enable already set
      wait_done(2, 7);
      check_count("descriptor reads", i_mem.rd_cnt - rd0, 8);
      check_burst(1'b0, rd0, 32'h200);
      check_burst(1'b0, rd0 + 4, 32'h280);    // follows beat 0 pointer
      reg_read(dma_pkg::REG_DAR, d);
      check_adr("dar", d[31:3], to_adr(32'h280));
   endtask

   task automatic test_ctl_writeback();
      int                       wr0;
      logic [dma_pkg::DC_W-1:0] dc;
      wr0 = i_mem.wr_cnt;
      dc  = make_dc(8'd6, 1'b0, 1'b0, 1'b1);
      put_desc(32'h300, 32'h0, 32'h400, dc);
      reg_write(dma_pkg::REG_NDAR, 32'h300);
      wait_done(1, 6);
      check_count("status writes", i_mem.wr_cnt - wr0, 4);
      check_burst(1'b1, wr0, 32'h400);
      for (int i = 0; i < dma_pkg::DESC_BEATS; i++) begin
         check_dc("status dc", i_mem.wr_dat_log[wr0 + i][dma_pkg::DC_W-1:0], dc);
      end
   endtask

   task automatic test_interrupt();
      logic [31:0] d;
      check_bit("int_o", int_o, 1'b0);
      put_desc(32'h480, 32'h0, 32'h0, make_dc(8'd2, 1'b0, 1'b1, 1'b0));
      reg_write(dma_pkg::REG_NDAR, 32'h480);
      wait_done(1, 2);
      check_bit("int_o", int_o, 1'b1);
      reg_read(dma_pkg::REG_STAT, d);
      check_bit("stat int", d[1], 1'b1);
      check_bit("stat busy", d[0], 1'b0);
      repeat (3) @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b1);        // held until cleared
      reg_write(dma_pkg::REG_STAT, 32'h1);
      repeat (2) @(negedge wb_clk_i);
      check_bit("int_o", int_o, 1'b0);
      reg_read(dma_pkg::REG_STAT, d);
      check_bit("stat int", d[1], 1'b0);
      put_desc(32'h500, 32'h0, 32'h0, make_dc(8'd2, 1'b0, 1'b0, 1'b0));
      reg_write(dma_pkg::REG_NDAR, 32'h500);
      wait_done(1, 2);
      check_bit("int_o", int_o, 1'b0);
   endtask

   task automatic test_append();
      int          rd0;
      logic [31:0] d;
      rd0 = i_mem.rd_cnt;
      put_desc(32'h580, 32'h0, 32'h0, make_dc(8'd3, 1'b0, 1'b0, 1'b0));
      // patch the finished descriptor at dar to point on
      put_desc(32'h500, 32'h580, 32'h0, make_dc(8'd2, 1'b1, 1'b0, 1'b0));
      reg_write(dma_pkg::REG_CTRL, 32'h3);
      wait_done(2, 5);
      check_count("descriptor reads", i_mem.rd_cnt - rd0, 8);
      check_burst(1'b0, rd0, 32'h500);
      check_burst(1'b0, rd0 + 4, 32'h580);
      reg_read(dma_pkg::REG_CTRL, d);
      check_bit("append", d[1], 1'b0);
      check_bit("enable", d[0], 1'b1);
      reg_read(dma_pkg::REG_DAR, d);
      check_adr("dar", d[31:3], to_adr(32'h580));
   endtask

   task automatic test_dirty();
      int          rd0;
      logic [31:0] d;
      reg_write(dma_pkg::REG_CTRL, 32'h0);
      put_desc(32'h600, 32'h0, 32'h0, make_dc(8'd1, 1'b0, 1'b0, 1'b0));
      rd0 = i_mem.rd_cnt;
      reg_write(dma_pkg::REG_NDAR, 32'h600);
      repeat (8) begin
         @(negedge wb_clk_i);
         check_bit("wbm_cyc_o", wbm_cyc_o, 1'b0);   // disabled, no bus cycle
      end
      check_count("reads while disabled", i_mem.rd_cnt - rd0, 0);
      reg_read(dma_pkg::REG_CTRL, d);
      check_bit("dirty", d[2], 1'b1);
      reg_write(dma_pkg::REG_CTRL, 32'h1);
      reg_read(dma_pkg::REG_STAT, d);
      check_bit("stat busy", d[0], 1'b1);
      wait_done(1, 1);
      reg_read(dma_pkg::REG_CTRL, d);
      check_bit("dirty", d[2], 1'b0);
      check_count("descriptor reads", i_mem.rd_cnt - rd0, 4);
      check_burst(1'b0, rd0, 32'h600);
   endtask

   initial begin
      wb_clk_i    = 1'b0;
      wb_rst_i    = 1'b1;
      wbm_err_i   = 1'b0;
      wbm_rty_i   = 1'b0;
      reg_we_i    = 1'b0;
      reg_adr_i   = 2'd0;
      reg_dat_i   = 32'd0;
      ld_we       = 1'b0;
      ld_idx      = 8'd0;
      ld_dat      = 64'd0;
      errors      = 0;
      checks      = 0;
      wd_armed    = 1'b0;
      wd_deadline = 0;
      repeat (5) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      check_bit("wbm_cyc_o", wbm_cyc_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("int_o", int_o, 1'b0);
      test_single();
      test_chain();
      test_ctl_writeback();
      test_interrupt();
      test_append();
      test_dirty();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: sim/wb_mem_model.sv
// wishbone memory model: 64-bit words, variable ack delay, logs reads and writes
module wb_mem_model (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [63:0] dat_i,
   output logic [63:0] dat_o,
   output logic        ack_o,
   input  logic [1:0]  delay_i,    // wait cycles before the next ack
   input  logic        ld_we_i,    // backdoor load port
   input  logic [7:0]  ld_idx_i,
   input  logic [63:0] ld_dat_i
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [63:0] mem [256];
   logic [7:0]  idx;
   logic [1:0]  wait_q;
   logic [31:0] rd_log [64];       // byte address of each read beat
   logic [31:0] wr_adr_log [64];
   logic [63:0] wr_dat_log [64];
   int          rd_cnt;
   int          wr_cnt;

   assign idx = adr_i[10:3];

   // fill pattern carries the word index in both halves
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {32'h5a5a0000 | 32'(i), 32'(i) << 3};
      end
   end

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o  <= 1'b0;
         dat_o  <= '0;
         wait_q <= 2'd1;
         rd_cnt <= 0;
         wr_cnt <= 0;
      end else begin
         if (ld_we_i) begin
            mem[ld_idx_i] <= ld_dat_i;
         end
         if (ack_o) begin
            ack_o  <= 1'b0;          // dead cycle between beats
            wait_q <= 2'd1;
         end else if (cyc_i && stb_i) begin
            if (wait_q >= delay_i) begin
               ack_o <= 1'b1;
               dat_o <= mem[idx];
               if (we_i) begin
                  mem[idx] <= dat_i;
                  if (wr_cnt < 64) begin
                     wr_adr_log[wr_cnt] <= adr_i;
                     wr_dat_log[wr_cnt] <= dat_i;
                  end
                  wr_cnt <= wr_cnt + 1;
               end else begin
                  if (rd_cnt < 64) begin
                     rd_log[rd_cnt] <= adr_i;
                  end
                  rd_cnt <= rd_cnt + 1;
               end
            end else begin
               wait_q <= wait_q + 2'd1;
            end
         end
      end
   end

endmodule
